/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define DATA_W 32
`define REG_AW 5

// Primary opcodes
`define OP_RTYPE 6'h00
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// SPECIAL funct field
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

`endif

/* logic/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    // Same 32-bit word, two field layouts
    typedef union packed {
        struct packed {
            logic [5:0]         op;
            logic [`REG_AW-1:0] rs;
            logic [`REG_AW-1:0] rt;
            logic [`REG_AW-1:0] rd;
            logic [4:0]         shamt;
            logic [5:0]         funct;
        } r;
        struct packed {
            logic [5:0]         op;
            logic [`REG_AW-1:0] rs;
            logic [`REG_AW-1:0] rt;
            logic [15:0]        imm;
        } i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

endpackage

/* logic/inst_decode.sv */
`include "core_defs.svh"

module inst_decode import core_pkg::*; (
    input  logic [`DATA_W-1:0] inst,
    output alu_op_e            aluop,
    output logic [`REG_AW-1:0] rs,
    output logic [`REG_AW-1:0] rt,
    output logic [`REG_AW-1:0] reg_waddr,
    output logic               reg_wen,
    output logic               read_rs,
    output logic               read_rt,
    output logic               use_imm,
    output logic               mem_en,
    output logic               mem_write,
    output logic               except,
    output logic [`DATA_W-1:0] imm_value,
    output logic [4:0]         shamt
);

    inst_u              word;
    logic [`DATA_W-1:0] imm_sext;
    logic [`DATA_W-1:0] imm_zext;

    assign word  = inst;
    assign rs    = word.i.rs;
    assign rt    = word.i.rt;
    assign shamt = word.r.shamt;

    assign imm_sext = {{(`DATA_W-16){word.i.imm[15]}}, word.i.imm};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, word.i.imm};

    always_comb begin
        // I-type arithmetic is the default shape
        aluop     = ALU_ADD;
        reg_waddr = word.i.rt;
        reg_wen   = 1'b1;
        read_rs   = 1'b1;
        read_rt   = 1'b0;
        use_imm   = 1'b1;
        imm_value = imm_sext;
        mem_en    = 1'b0;
        mem_write = 1'b0;
        except    = 1'b0;

        case (word.i.op)
            `OP_RTYPE: begin
                reg_waddr = word.r.rd;
                read_rt   = 1'b1;
                use_imm   = 1'b0;
                imm_value = '0;
                case (word.r.funct)
                    `FN_ADDU: aluop = ALU_ADD;
                    `FN_SUBU: aluop = ALU_SUB;
                    `FN_AND:  aluop = ALU_AND;
                    `FN_OR:   aluop = ALU_OR;
                    `FN_XOR:  aluop = ALU_XOR;
                    `FN_SLT:  aluop = ALU_SLT;
                    `FN_SLL: begin
                        aluop   = ALU_SLL;
                        read_rs = 1'b0;
                    end
                    `FN_SRL: begin
                        aluop   = ALU_SRL;
                        read_rs = 1'b0;
                    end
                    default: except = 1'b1;
                endcase
            end
            `OP_ADDIU: aluop = ALU_ADD;
            `OP_SLTI:  aluop = ALU_SLT;
            `OP_ANDI: begin
                aluop     = ALU_AND;
                imm_value = imm_zext;
            end
            `OP_ORI: begin
                aluop     = ALU_OR;
                imm_value = imm_zext;
            end
            `OP_XORI: begin
                aluop     = ALU_XOR;
                imm_value = imm_zext;
            end
            `OP_LUI: begin
                aluop     = ALU_LUI;
                read_rs   = 1'b0;
                imm_value = imm_zext;
            end
            `OP_LW: mem_en = 1'b1;
            `OP_SW: begin
                mem_en    = 1'b1;
                mem_write = 1'b1;
                reg_wen   = 1'b0;
                read_rt   = 1'b1;
            end
            default: except = 1'b1;
        endcase

        // Illegal word has no side effects
        if (except) begin
            reg_wen   = 1'b0;
            mem_en    = 1'b0;
            mem_write = 1'b0;
            read_rs   = 1'b0;
            read_rt   = 1'b0;
        end
    end

endmodule

/* logic/issue_ctrl.sv */
`include "core_defs.svh"

module issue_ctrl (
    input  logic               inst_valid0,
    input  logic               inst_valid1,
    input  logic               stall,
    input  logic               flush,
    input  logic               m_reg_wen,
    input  logic               m_mem_en,
    input  logic [`REG_AW-1:0] m_reg_waddr,
    input  logic               s_read_rs,
    input  logic               s_read_rt,
    input  logic               s_mem_en,
    input  logic [`REG_AW-1:0] s_rs,
    input  logic [`REG_AW-1:0] s_rt,
    output logic               ena1,
    output logic               ena2,
    output logic               clear1,
    output logic               clear2,
    output logic               slave_issued
);

    logic raw_rs;
    logic raw_rt;
    logic raw_hazard;
    logic mem_pair;

    ////////////////////
    // Pairing rule
    ////////////////////

    assign raw_rs     = s_read_rs && (s_rs == m_reg_waddr);
    assign raw_rt     = s_read_rt && (s_rt == m_reg_waddr);
    // r0 never carries a dependency
    assign raw_hazard = m_reg_wen && (m_reg_waddr != '0) && (raw_rs || raw_rt);
    // Only one memory port
    assign mem_pair   = m_mem_en && s_mem_en;

    assign slave_issued = inst_valid0 && inst_valid1 && !raw_hazard && !mem_pair;

    ////////////////////
    // Register control
    ////////////////////

    assign ena1 = !stall;
    assign ena2 = !stall;

    // Flush clears even under stall; id_ex gives clear priority
    assign clear1 = flush || (!stall && !inst_valid0);
    assign clear2 = flush || (!stall && !slave_issued);

endmodule

/* logic/id_ex.sv */
`include "core_defs.svh"

module id_ex import core_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ena1,
    input  logic               ena2,
    input  logic               clear1,
    input  logic               clear2,

    // Master slot from decode
    input  alu_op_e            m_aluop,
    input  logic [`REG_AW-1:0] m_reg_waddr,
    input  logic               m_reg_wen,
    input  logic               m_use_imm,
    input  logic               m_mem_en,
    input  logic               m_mem_write,
    input  logic               m_except,
    input  logic [4:0]         m_shamt,
    input  logic [`DATA_W-1:0] m_imm_value,
    input  logic [`DATA_W-1:0] m_rs_value,
    input  logic [`DATA_W-1:0] m_rt_value,
    input  logic [`DATA_W-1:0] m_pc,

    // Slave slot from decode
    input  alu_op_e            s_aluop,
    input  logic [`REG_AW-1:0] s_reg_waddr,
    input  logic               s_reg_wen,
    input  logic               s_use_imm,
    input  logic               s_mem_en,
    input  logic               s_mem_write,
    input  logic               s_except,
    input  logic [4:0]         s_shamt,
    input  logic [`DATA_W-1:0] s_imm_value,
    input  logic [`DATA_W-1:0] s_rs_value,
    input  logic [`DATA_W-1:0] s_rt_value,
    input  logic [`DATA_W-1:0] s_pc,

    output logic               e_m_valid,
    output alu_op_e            e_m_aluop,
    output logic [`REG_AW-1:0] e_m_reg_waddr,
    output logic               e_m_reg_wen,
    output logic               e_m_use_imm,
    output logic               e_m_mem_en,
    output logic               e_m_mem_write,
    output logic               e_m_except,
    output logic [4:0]         e_m_shamt,
    output logic [`DATA_W-1:0] e_m_imm_value,
    output logic [`DATA_W-1:0] e_m_rs_value,
    output logic [`DATA_W-1:0] e_m_rt_value,
    output logic [`DATA_W-1:0] e_m_pc,

    output logic               e_s_valid,
    output alu_op_e            e_s_aluop,
    output logic [`REG_AW-1:0] e_s_reg_waddr,
    output logic               e_s_reg_wen,
    output logic               e_s_use_imm,
    output logic               e_s_mem_en,
    output logic               e_s_mem_write,
    output logic               e_s_except,
    output logic [4:0]         e_s_shamt,
    output logic [`DATA_W-1:0] e_s_imm_value,
    output logic [`DATA_W-1:0] e_s_rs_value,
    output logic [`DATA_W-1:0] e_s_rt_value,
    output logic [`DATA_W-1:0] e_s_pc
);

    // valid, aluop, waddr, five flags, shamt, then four data words
    localparam int OP_W   = $bits(alu_op_e);
    localparam int BANK_W = 4 * `DATA_W + `REG_AW + OP_W + 11;

    logic [BANK_W-1:0] m_d;
    logic [BANK_W-1:0] m_q;
    logic [BANK_W-1:0] s_d;
    logic [BANK_W-1:0] s_q;
    logic [OP_W-1:0]   m_aluop_q;
    logic [OP_W-1:0]   s_aluop_q;

    // Leading 1 is the valid bit, set whenever the slot loads
    assign m_d = {1'b1, m_aluop, m_reg_waddr, m_reg_wen, m_use_imm, m_mem_en,
                  m_mem_write, m_except, m_shamt, m_imm_value, m_rs_value,
                  m_rt_value, m_pc};
    assign s_d = {1'b1, s_aluop, s_reg_waddr, s_reg_wen, s_use_imm, s_mem_en,
                  s_mem_write, s_except, s_shamt, s_imm_value, s_rs_value,
                  s_rt_value, s_pc};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_q <= '0;
        end else if (clear1) begin
            m_q <= '0;
        end else if (ena1) begin
            m_q <= m_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s_q <= '0;
        end else if (clear2) begin
            s_q <= '0;
        end else if (ena2) begin
            s_q <= s_d;
        end
    end

    assign {e_m_valid, m_aluop_q, e_m_reg_waddr, e_m_reg_wen, e_m_use_imm, e_m_mem_en,
            e_m_mem_write, e_m_except, e_m_shamt, e_m_imm_value, e_m_rs_value,
            e_m_rt_value, e_m_pc} = m_q;
    assign {e_s_valid, s_aluop_q, e_s_reg_waddr, e_s_reg_wen, e_s_use_imm, e_s_mem_en,
            e_s_mem_write, e_s_except, e_s_shamt, e_s_imm_value, e_s_rs_value,
            e_s_rt_value, e_s_pc} = s_q;

    assign e_m_aluop = alu_op_e'(m_aluop_q);
    assign e_s_aluop = alu_op_e'(s_aluop_q);

endmodule

/* logic/exec_alu.sv */
`include "core_defs.svh"

module exec_alu import core_pkg::*; (
    input  alu_op_e            aluop,
    input  logic               use_imm,
    input  logic [`DATA_W-1:0] rs_value,
    input  logic [`DATA_W-1:0] rt_value,
    input  logic [`DATA_W-1:0] imm_value,
    input  logic [4:0]         shamt,
    output logic [`DATA_W-1:0] result
);

    logic [`DATA_W-1:0] op_b;
    logic               lt_signed;

    assign op_b      = use_imm ? imm_value : rt_value;
    assign lt_signed = $signed(rs_value) < $signed(op_b);

    always_comb begin
        case (aluop)
            // Loads and stores land here too, giving the address
            ALU_ADD: result = rs_value + op_b;
            ALU_SUB: result = rs_value - op_b;
            ALU_AND: result = rs_value & op_b;
            ALU_OR:  result = rs_value | op_b;
            ALU_XOR: result = rs_value ^ op_b;
            ALU_SLT: result = {{(`DATA_W-1){1'b0}}, lt_signed};
            // Shifts act on rt only
            ALU_SLL: result = rt_value << shamt;
            ALU_SRL: result = rt_value >> shamt;
            ALU_LUI: result = {imm_value[15:0], {(`DATA_W-16){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

/* logic/dual_issue_top.sv */
`include "core_defs.svh"

module dual_issue_top import core_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_valid0,
    input  logic               inst_valid1,
    input  logic               stall,
    input  logic               flush,
    input  logic [`DATA_W-1:0] inst0,
    input  logic [`DATA_W-1:0] inst1,
    input  logic [`DATA_W-1:0] rs_value0,
    input  logic [`DATA_W-1:0] rt_value0,
    input  logic [`DATA_W-1:0] rs_value1,
    input  logic [`DATA_W-1:0] rt_value1,
    input  logic [`DATA_W-1:0] pc0,
    input  logic [`DATA_W-1:0] pc1,
    output logic               slave_issued,
    output logic               e_valid0,
    output logic               e_reg_wen0,
    output logic               e_mem_en0,
    output logic               e_mem_write0,
    output logic               e_except0,
    output logic [`REG_AW-1:0] e_waddr0,
    output logic [`DATA_W-1:0] e_result0,
    output logic [`DATA_W-1:0] e_store_data0,
    output logic [`DATA_W-1:0] e_pc0,
    output logic               e_valid1,
    output logic               e_reg_wen1,
    output logic               e_mem_en1,
    output logic               e_mem_write1,
    output logic               e_except1,
    output logic [`REG_AW-1:0] e_waddr1,
    output logic [`DATA_W-1:0] e_result1,
    output logic [`DATA_W-1:0] e_store_data1,
    output logic [`DATA_W-1:0] e_pc1
);

    // Decode stage
    alu_op_e            m_aluop;
    alu_op_e            s_aluop;
    logic [`REG_AW-1:0] m_reg_waddr;
    logic [`REG_AW-1:0] s_reg_waddr;
    logic [`REG_AW-1:0] s_rs;
    logic [`REG_AW-1:0] s_rt;
    logic               m_reg_wen, m_use_imm, m_mem_en, m_mem_write, m_except;
    logic               s_reg_wen, s_use_imm, s_mem_en, s_mem_write, s_except;
    logic               s_read_rs, s_read_rt;
    logic [4:0]         m_shamt;
    logic [4:0]         s_shamt;
    logic [`DATA_W-1:0] m_imm_value;
    logic [`DATA_W-1:0] s_imm_value;
    logic               ena1, ena2, clear1, clear2;

    // Execute stage
    alu_op_e            e_m_aluop;
    alu_op_e            e_s_aluop;
    logic               e_m_use_imm, e_s_use_imm;
    logic [4:0]         e_m_shamt;
    logic [4:0]         e_s_shamt;
    logic [`DATA_W-1:0] e_m_imm_value, e_s_imm_value;
    logic [`DATA_W-1:0] e_m_rs_value, e_s_rs_value;

    ////////////////////
    // Decode
    ////////////////////

    // Master operand flags are not needed here
    inst_decode u_dec_m (
        .inst(inst0), .aluop(m_aluop), .rs(), .rt(),
        .reg_waddr(m_reg_waddr), .reg_wen(m_reg_wen),
        .read_rs(), .read_rt(), .use_imm(m_use_imm),
        .mem_en(m_mem_en), .mem_write(m_mem_write), .except(m_except),
        .imm_value(m_imm_value), .shamt(m_shamt)
    );

    inst_decode u_dec_s (
        .inst(inst1), .aluop(s_aluop), .rs(s_rs), .rt(s_rt),
        .reg_waddr(s_reg_waddr), .reg_wen(s_reg_wen),
        .read_rs(s_read_rs), .read_rt(s_read_rt), .use_imm(s_use_imm),
        .mem_en(s_mem_en), .mem_write(s_mem_write), .except(s_except),
        .imm_value(s_imm_value), .shamt(s_shamt)
    );

    issue_ctrl u_issue (
        .inst_valid0(inst_valid0), .inst_valid1(inst_valid1),
        .stall(stall), .flush(flush),
        .m_reg_wen(m_reg_wen), .m_mem_en(m_mem_en), .m_reg_waddr(m_reg_waddr),
        .s_read_rs(s_read_rs), .s_read_rt(s_read_rt), .s_mem_en(s_mem_en),
        .s_rs(s_rs), .s_rt(s_rt),
        .ena1(ena1), .ena2(ena2), .clear1(clear1), .clear2(clear2),
        .slave_issued(slave_issued)
    );

    ////////////////////
    // ID/EX and execute
    ////////////////////

    id_ex u_id_ex (
        .clk(clk), .arst_n(arst_n),
        .ena1(ena1), .ena2(ena2), .clear1(clear1), .clear2(clear2),
        .m_aluop(m_aluop), .m_reg_waddr(m_reg_waddr), .m_reg_wen(m_reg_wen),
        .m_use_imm(m_use_imm), .m_mem_en(m_mem_en), .m_mem_write(m_mem_write),
        .m_except(m_except), .m_shamt(m_shamt), .m_imm_value(m_imm_value),
        .m_rs_value(rs_value0), .m_rt_value(rt_value0), .m_pc(pc0),
        .s_aluop(s_aluop), .s_reg_waddr(s_reg_waddr), .s_reg_wen(s_reg_wen),
        .s_use_imm(s_use_imm), .s_mem_en(s_mem_en), .s_mem_write(s_mem_write),
        .s_except(s_except), .s_shamt(s_shamt), .s_imm_value(s_imm_value),
        .s_rs_value(rs_value1), .s_rt_value(rt_value1), .s_pc(pc1),
        .e_m_valid(e_valid0), .e_m_aluop(e_m_aluop), .e_m_reg_waddr(e_waddr0),
        .e_m_reg_wen(e_reg_wen0), .e_m_use_imm(e_m_use_imm), .e_m_mem_en(e_mem_en0),
        .e_m_mem_write(e_mem_write0), .e_m_except(e_except0), .e_m_shamt(e_m_shamt),
        .e_m_imm_value(e_m_imm_value), .e_m_rs_value(e_m_rs_value),
        .e_m_rt_value(e_store_data0), .e_m_pc(e_pc0),
        .e_s_valid(e_valid1), .e_s_aluop(e_s_aluop), .e_s_reg_waddr(e_waddr1),
        .e_s_reg_wen(e_reg_wen1), .e_s_use_imm(e_s_use_imm), .e_s_mem_en(e_mem_en1),
        .e_s_mem_write(e_mem_write1), .e_s_except(e_except1), .e_s_shamt(e_s_shamt),
        .e_s_imm_value(e_s_imm_value), .e_s_rs_value(e_s_rs_value),
        .e_s_rt_value(e_store_data1), .e_s_pc(e_pc1)
    );

    // Registered rt doubles as store data and ALU operand
    exec_alu u_alu_m (
        .aluop(e_m_aluop), .use_imm(e_m_use_imm),
        .rs_value(e_m_rs_value), .rt_value(e_store_data0),
        .imm_value(e_m_imm_value), .shamt(e_m_shamt),
        .result(e_result0)
    );

    exec_alu u_alu_s (
        .aluop(e_s_aluop), .use_imm(e_s_use_imm),
        .rs_value(e_s_rs_value), .rt_value(e_store_data1),
        .imm_value(e_s_imm_value), .shamt(e_s_shamt),
        .result(e_result1)
    );

endmodule

/* tb/tb_dual_issue.sv */
`include "core_defs.svh"

module tb_dual_issue import core_pkg::*; ();

    localparam int CYCLE_LIMIT = 2000;
    localparam logic [47:0] FN_SET = {`FN_SRL, `FN_SLL, `FN_SLT, `FN_XOR, `FN_OR, `FN_AND,
                                      `FN_SUBU, `FN_ADDU};
    localparam logic [47:0] OP_SET = {`OP_SW, `OP_LW, `OP_LUI, `OP_XORI, `OP_ORI, `OP_ANDI,
                                      `OP_SLTI, `OP_ADDIU};

    logic               clk, arst_n, inst_valid0, inst_valid1, stall, flush;
    logic [`DATA_W-1:0] inst0, inst1, rs_value0, rt_value0, rs_value1, rt_value1, pc0, pc1;
    logic               slave_issued;
    logic               e_valid0, e_reg_wen0, e_mem_en0, e_mem_write0, e_except0;
    logic               e_valid1, e_reg_wen1, e_mem_en1, e_mem_write1, e_except1;
    logic [`REG_AW-1:0] e_waddr0, e_waddr1;
    logic [`DATA_W-1:0] e_result0, e_store_data0, e_pc0, e_result1, e_store_data1, e_pc1;

    // c_ holds this cycle's decode and x_ what E must show
    logic [1:0]                    c_wen, c_mem, c_wr, c_exc, c_rd_rs, c_rd_rt;
    logic [1:0][`REG_AW-1:0]       c_wa;
    logic [1:0][`DATA_W-1:0]       c_res, in_rt, in_pc;
    logic [1:0]                    x_valid, x_wen, x_mem, x_wr, x_exc;
    logic [1:0][`REG_AW-1:0]       x_wa;
    logic [1:0][`DATA_W-1:0]       x_res, x_st, x_pc;
    logic                          exp_issue;
    inst_u                         s_word;
    int                            err_cnt, mark, tests_ok, tests_bad, cycles;

    dual_issue_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] r_op(input logic [5:0] fn, input logic [4:0] rs, rt, rd, sh);
        return {`OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_op(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // k 0..7 are R-type, 8..15 I-type with LW and SW last
    function automatic logic [31:0] rand_inst(input int k, input logic [4:0] rs, rt, rd);
        if (k < 8)
            return r_op(FN_SET[k*6 +: 6], rs, rt, rd, 5'($urandom));
        return i_op(OP_SET[(k-8)*6 +: 6], rs, rt, 16'($urandom));
    endfunction

    function automatic void model_slot(input logic [31:0] w, rsv, rtv, output logic [31:0] res,
                                       output logic wen, mem, wr, exc, use_rs, use_rt,
                                       output logic [4:0] wa);
        inst_u       u;
        logic [31:0] se;
        logic [31:0] ze;
        u = w;
        se = {{16{u.i.imm[15]}}, u.i.imm};
        ze = {16'h0, u.i.imm};
        res = '0;
        {wen, mem, wr, exc, use_rs, use_rt} = 6'b100010;
        wa = u.i.rt;
        case (u.i.op)
            `OP_RTYPE: begin
                wa = u.r.rd;
                use_rt = 1'b1;
                case (u.r.funct)
                    `FN_ADDU: res = rsv + rtv;
                    `FN_SUBU: res = rsv - rtv;
                    `FN_AND:  res = rsv & rtv;
                    `FN_OR:   res = rsv | rtv;
                    `FN_XOR:  res = rsv ^ rtv;
                    `FN_SLT:  res = {31'h0, $signed(rsv) < $signed(rtv)};
                    `FN_SLL:  {use_rs, res} = {1'b0, rtv << u.r.shamt};
                    `FN_SRL:  {use_rs, res} = {1'b0, rtv >> u.r.shamt};
                    default:  exc = 1'b1;
                endcase
            end
            `OP_ADDIU: res = rsv + se;
            `OP_SLTI:  res = {31'h0, $signed(rsv) < $signed(se)};
            `OP_ANDI:  res = rsv & ze;
            `OP_ORI:   res = rsv | ze;
            `OP_XORI:  res = rsv ^ ze;
            `OP_LUI:   {use_rs, res} = {1'b0, u.i.imm, 16'h0};
            `OP_LW:    {mem, res} = {1'b1, rsv + se};
            `OP_SW:    {wen, mem, wr, use_rt, res} = {4'b0111, rsv + se};
            default:   exc = 1'b1;
        endcase
        if (exc)
            {wen, mem, wr, use_rs, use_rt} = 5'b0;
    endfunction

    assign in_rt  = {rt_value1, rt_value0};
    assign in_pc  = {pc1, pc0};
    assign s_word = inst1;

    always_comb begin
        model_slot(inst0, rs_value0, rt_value0, c_res[0], c_wen[0], c_mem[0], c_wr[0],
                   c_exc[0], c_rd_rs[0], c_rd_rt[0], c_wa[0]);
        model_slot(inst1, rs_value1, rt_value1, c_res[1], c_wen[1], c_mem[1], c_wr[1],
                   c_exc[1], c_rd_rs[1], c_rd_rt[1], c_wa[1]);
    end

    // Slave refused on a RAW against a nonzero master target, or two memory ops
    assign exp_issue = inst_valid0 && inst_valid1 && !(c_mem[0] && c_mem[1])
        && !(c_wen[0] && c_wa[0] != '0 && ((c_rd_rs[1] && s_word.r.rs == c_wa[0])
        || (c_rd_rt[1] && s_word.r.rt == c_wa[0])));

    always @(posedge clk or negedge arst_n) begin
        logic take;
        for (int n = 0; n < 2; n++) begin
            take = arst_n && !flush && ((n == 0) ? inst_valid0 : exp_issue);
            if (!arst_n || flush || !stall) begin
                x_valid[n] <= take;
                x_wen[n]   <= take && c_wen[n];
                x_mem[n]   <= take && c_mem[n];
                x_wr[n]    <= take && c_wr[n];
                x_exc[n]   <= take && c_exc[n];
                x_wa[n]    <= take ? c_wa[n] : '0;
                x_res[n]   <= take ? c_res[n] : '0;
                x_st[n]    <= take ? in_rt[n] : '0;
                x_pc[n]    <= take ? in_pc[n] : '0;
            end
        end
    end

    task automatic show_mismatch(input string name, input logic [31:0] exp, act);
        $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
        err_cnt++;
    endtask

    ////////////////////
    // Checks
    ////////////////////

    a_issue: assert property (@(posedge clk) slave_issued == exp_issue)
        else show_mismatch("slave_issued", 32'($sampled(exp_issue)), 32'($sampled(slave_issued)));
    a_v0: assert property (@(posedge clk) e_valid0 == x_valid[0])
        else show_mismatch("e_valid0", 32'($sampled(x_valid[0])), 32'($sampled(e_valid0)));
    a_v1: assert property (@(posedge clk) e_valid1 == x_valid[1])
        else show_mismatch("e_valid1", 32'($sampled(x_valid[1])), 32'($sampled(e_valid1)));
    a_wen0: assert property (@(posedge clk) e_reg_wen0 == x_wen[0])
        else show_mismatch("e_reg_wen0", 32'($sampled(x_wen[0])), 32'($sampled(e_reg_wen0)));
    a_wen1: assert property (@(posedge clk) e_reg_wen1 == x_wen[1])
        else show_mismatch("e_reg_wen1", 32'($sampled(x_wen[1])), 32'($sampled(e_reg_wen1)));
    a_mem0: assert property (@(posedge clk) e_mem_en0 == x_mem[0])
        else show_mismatch("e_mem_en0", 32'($sampled(x_mem[0])), 32'($sampled(e_mem_en0)));
    a_mem1: assert property (@(posedge clk) e_mem_en1 == x_mem[1])
        else show_mismatch("e_mem_en1", 32'($sampled(x_mem[1])), 32'($sampled(e_mem_en1)));
    a_wr0: assert property (@(posedge clk) e_mem_write0 == x_wr[0])
        else show_mismatch("e_mem_write0", 32'($sampled(x_wr[0])), 32'($sampled(e_mem_write0)));
    a_wr1: assert property (@(posedge clk) e_mem_write1 == x_wr[1])
        else show_mismatch("e_mem_write1", 32'($sampled(x_wr[1])), 32'($sampled(e_mem_write1)));
    a_exc0: assert property (@(posedge clk) e_except0 == x_exc[0])
        else show_mismatch("e_except0", 32'($sampled(x_exc[0])), 32'($sampled(e_except0)));
    a_exc1: assert property (@(posedge clk) e_except1 == x_exc[1])
        else show_mismatch("e_except1", 32'($sampled(x_exc[1])), 32'($sampled(e_except1)));
    a_wa0: assert property (@(posedge clk) e_waddr0 == x_wa[0])
        else show_mismatch("e_waddr0", 32'($sampled(x_wa[0])), 32'($sampled(e_waddr0)));
    a_wa1: assert property (@(posedge clk) e_waddr1 == x_wa[1])
        else show_mismatch("e_waddr1", 32'($sampled(x_wa[1])), 32'($sampled(e_waddr1)));
    // Result of an illegal word is not defined
    a_res0: assert property (@(posedge clk) x_exc[0] || e_result0 == x_res[0])
        else show_mismatch("e_result0", $sampled(x_res[0]), $sampled(e_result0));
    a_res1: assert property (@(posedge clk) x_exc[1] || e_result1 == x_res[1])
        else show_mismatch("e_result1", $sampled(x_res[1]), $sampled(e_result1));
    a_st0: assert property (@(posedge clk) e_store_data0 == x_st[0])
        else show_mismatch("e_store_data0", $sampled(x_st[0]), $sampled(e_store_data0));
    a_st1: assert property (@(posedge clk) e_store_data1 == x_st[1])
        else show_mismatch("e_store_data1", $sampled(x_st[1]), $sampled(e_store_data1));
    a_pc0: assert property (@(posedge clk) e_pc0 == x_pc[0])
        else show_mismatch("e_pc0", $sampled(x_pc[0]), $sampled(e_pc0));
    a_pc1: assert property (@(posedge clk) e_pc1 == x_pc[1])
        else show_mismatch("e_pc1", $sampled(x_pc[1]), $sampled(e_pc1));

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive(input logic [31:0] w0, w1, input logic v0, v1, st, fl);
        @(posedge clk);
        inst0       <= w0;
        inst1       <= w1;
        inst_valid0 <= v0;
        inst_valid1 <= v1;
        stall       <= st;
        flush       <= fl;
        rs_value0   <= $urandom;
        rt_value0   <= $urandom;
        rs_value1   <= $urandom;
        rt_value1   <= $urandom;
        pc0         <= pc0 + 32'd8;
        pc1         <= pc0 + 32'd12;
    endtask

    // One idle cycle lets the last pair reach its check
    task automatic end_test(input string name);
        drive('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        @(posedge clk);
        #1;
        if (err_cnt == mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_cnt - mark);
        end
        mark = err_cnt;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, run stopped", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hc226_5cf1));
        {arst_n, inst_valid0, inst_valid1, stall, flush} = 5'b0;
        {inst0, inst1, rs_value0, rt_value0, rs_value1, rt_value1, pc0, pc1} = '0;
        {err_cnt, mark, tests_ok, tests_bad, cycles} = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) drive('0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        end_test("reset");

        // Slave sources 16..31 never meet master targets 1..15
        repeat (60) drive(rand_inst($urandom_range(15, 0), 5'($urandom), 5'($urandom_range(15, 1)),
                                    5'($urandom_range(15, 1))),
                          rand_inst($urandom_range(13, 0), 5'($urandom_range(31, 16)),
                                    5'($urandom_range(31, 16)), 5'($urandom)),
                          1'b1, 1'b1, 1'b0, 1'b0);
        end_test("independent pairs");

        drive(r_op(`FN_ADDU, 1, 2, 5, 0), i_op(`OP_ADDIU, 5, 7, 16'h0010), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(r_op(`FN_ADDU, 1, 2, 5, 0), r_op(`FN_SLL, 0, 5, 9, 3), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(i_op(`OP_LUI, 0, 6, 16'h1234), i_op(`OP_SW, 1, 6, 16'h0004), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(r_op(`FN_OR, 1, 2, 0, 0), i_op(`OP_ORI, 0, 7, 16'h00ff), 1'b1, 1'b1, 1'b0, 1'b0);
        repeat (40) drive(rand_inst($urandom_range(13, 0), 5'($urandom_range(3, 0)),
                                    5'($urandom_range(3, 0)), 5'($urandom_range(3, 0))),
                          rand_inst($urandom_range(13, 0), 5'($urandom_range(3, 0)),
                                    5'($urandom_range(3, 0)), 5'($urandom_range(3, 0))),
                          1'b1, 1'b1, 1'b0, 1'b0);
        end_test("dependent pairs");

        drive(i_op(`OP_LW, 1, 4, 16'hfff0), i_op(`OP_SW, 2, 3, 16'h0020), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(i_op(`OP_SW, 2, 3, 16'h8000), i_op(`OP_LW, 1, 9, 16'h0008), 1'b1, 1'b1, 1'b0, 1'b0);
        repeat (20) drive(rand_inst($urandom_range(15, 14), 5'($urandom), 5'($urandom), 5'd0),
                          rand_inst($urandom_range(15, 14), 5'($urandom), 5'($urandom), 5'd0),
                          1'b1, 1'b1, 1'b0, 1'b0);
        end_test("memory pairs");

        drive(rand_inst(0, 1, 2, 3), rand_inst(9, 8, 10, 0), 1'b1, 1'b1, 1'b0, 1'b0);
        repeat (3) drive(rand_inst(1, 4, 5, 6), rand_inst(12, 8, 11, 0), 1'b1, 1'b1, 1'b1, 1'b0);
        drive(rand_inst(2, 4, 5, 6), rand_inst(13, 8, 12, 0), 1'b1, 1'b1, 1'b1, 1'b1);
        drive(rand_inst(3, 4, 5, 6), rand_inst(10, 8, 13, 0), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(rand_inst(4, 4, 5, 6), rand_inst(11, 8, 14, 0), 1'b1, 1'b1, 1'b0, 1'b1);
        drive(rand_inst(5, 4, 5, 6), rand_inst(8, 8, 15, 0), 1'b1, 1'b0, 1'b0, 1'b0);
        end_test("stall and flush");

        drive(i_op(6'h3f, 1, 2, 16'h0001), rand_inst(0, 8, 9, 10), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(rand_inst(1, 1, 2, 3), r_op(6'h3f, 8, 9, 10, 0), 1'b1, 1'b1, 1'b0, 1'b0);
        drive(r_op(6'h08, 1, 2, 3, 0), i_op(6'h04, 8, 9, 16'h0002), 1'b1, 1'b1, 1'b0, 1'b0);
        repeat (10) drive(i_op(6'h01, 5'($urandom), 5'($urandom), 16'($urandom)),
                          rand_inst($urandom_range(15, 0), 5'($urandom), 5'($urandom), 5'($urandom)),
                          1'b1, 1'b1, 1'b0, 1'b0);
        end_test("illegal words");

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/core_pkg.sv
logic/inst_decode.sv
logic/issue_ctrl.sv
logic/id_ex.sv
logic/exec_alu.sv
logic/dual_issue_top.sv
tb/tb_dual_issue.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_dual_issue -o sim_dual_issue &&
./obj_dir/sim_dual_issue | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
